/* design/rename_settings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// two-way rename group
`define N_WAYS      2

`define ARCH_REGS   32
`define PHYS_REGS   64
`define FREE_SIZE   (`PHYS_REGS - `ARCH_REGS)

`define ARCH_W      5
`define PRN_W       6
`define FREE_PTR_W  5
`define FREE_CNT_W  6   // holds 0 to FREE_SIZE

`endif

/* design/rename_pkg.sv */
`default_nettype none

`include "rename_settings.svh"

package rename_pkg;

    // architectural register number as seen by decode
    typedef logic [`ARCH_W-1:0] arch_reg_t;

    // physical register number
    typedef logic [`PRN_W-1:0] prn_t;

endpackage

`default_nettype wire

/* design/rename_map.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rename_settings.svh"

module rename_map (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   squash,

    input  logic               [`N_WAYS-1:0]       dispatch_valid,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]    dispatch_dest,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]    dispatch_src1,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]    dispatch_src2,
    input  rename_pkg::prn_t   [`N_WAYS-1:0]       alloc_prn,
    input  logic                                   rename_stall,
    input  rename_pkg::prn_t   [`ARCH_REGS-1:0]    committed_map,

    output rename_pkg::prn_t   [`N_WAYS-1:0]       src1_prn,
    output rename_pkg::prn_t   [`N_WAYS-1:0]       src2_prn,
    output rename_pkg::prn_t   [`N_WAYS-1:0]       dest_prn,
    output rename_pkg::prn_t   [`N_WAYS-1:0]       old_prn
);

    rename_pkg::prn_t [`ARCH_REGS-1:0] map_table;  // speculative map

    always_comb begin
        int alloc_idx;

        alloc_idx = 0;
        for (int i = 0; i < `N_WAYS; i++) begin
            dest_prn[i] = alloc_prn[alloc_idx];   // invalid ways do not consume
            src1_prn[i] = map_table[dispatch_src1[i]];
            src2_prn[i] = map_table[dispatch_src2[i]];
            old_prn[i]  = map_table[dispatch_dest[i]];

            // younger ways see older destinations in the same group
            for (int j = 0; j < i; j++) begin
                if (dispatch_valid[j] && (dispatch_dest[j] == dispatch_src1[i])) begin
                    src1_prn[i] = dest_prn[j];
                end
                if (dispatch_valid[j] && (dispatch_dest[j] == dispatch_src2[i])) begin
                    src2_prn[i] = dest_prn[j];
                end
                if (dispatch_valid[j] && (dispatch_dest[j] == dispatch_dest[i])) begin
                    old_prn[i] = dest_prn[j];
                end
            end

            if (dispatch_valid[i]) begin
                alloc_idx = alloc_idx + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map_table[r] <= rename_pkg::prn_t'(r);  // identity mapping
            end
        end else if (squash) begin
            map_table <= committed_map;                 // back to committed state
        end else if (!rename_stall) begin
            // last way wins on a shared destination
            for (int i = 0; i < `N_WAYS; i++) begin
                if (dispatch_valid[i]) begin
                    map_table[dispatch_dest[i]] <= dest_prn[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/free_list.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rename_settings.svh"

module free_list #(
    parameter int SIZE = `FREE_SIZE
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                squash,
    input  logic             [`N_WAYS-1:0]      dispatch_valid,
    input  logic             [`N_WAYS-1:0]      retire_valid,
    input  rename_pkg::prn_t [`N_WAYS-1:0]      freed_prn,

    output rename_pkg::prn_t [`N_WAYS-1:0]      alloc_prn,
    output logic                                rename_stall
);

    rename_pkg::prn_t [SIZE-1:0] ring;

    logic [`FREE_PTR_W-1:0] spec_head;      // next PRN handed to rename
    logic [`FREE_PTR_W-1:0] ret_head;       // committed view of the head
    logic [`FREE_PTR_W-1:0] tail;           // shared by both views
    logic [`FREE_CNT_W-1:0] spec_count;

    logic [`FREE_PTR_W-1:0] spec_head_next;
    logic [`FREE_PTR_W-1:0] ret_head_next;
    logic [`FREE_PTR_W-1:0] tail_next;
    logic [`FREE_CNT_W-1:0] spec_count_next;
    logic [`FREE_CNT_W-1:0] alloc_cnt;
    logic [`FREE_CNT_W-1:0] push_cnt;
    logic [`FREE_PTR_W-1:0] push_idx [`N_WAYS];
    logic                   take;

    function automatic logic [`FREE_PTR_W-1:0] ptr_add(
        input logic [`FREE_PTR_W-1:0] ptr,
        input int unsigned            step
    );
        int unsigned sum;

        sum = ptr + step;
        if (sum >= SIZE) begin
            sum = sum - SIZE;
        end
        return sum[`FREE_PTR_W-1:0];
    endfunction

    assign rename_stall = (spec_count < `N_WAYS);
    assign take         = !squash && !rename_stall;

    always_comb begin
        alloc_cnt = '0;
        push_cnt  = '0;
        for (int i = 0; i < `N_WAYS; i++) begin
            alloc_prn[i] = ring[ptr_add(spec_head, i)];
            push_idx[i]  = ptr_add(tail, push_cnt);   // packed behind older ways
            if (dispatch_valid[i]) begin
                alloc_cnt = alloc_cnt + 1'b1;
            end
            if (retire_valid[i]) begin
                push_cnt = push_cnt + 1'b1;
            end
        end

        // each retirement frees one PRN and uses up one committed entry
        ret_head_next = ptr_add(ret_head, push_cnt);
        tail_next     = ptr_add(tail, push_cnt);

        if (squash) begin
            spec_head_next  = ret_head_next;
            spec_count_next = `FREE_CNT_W'(SIZE);   // committed list is always full
        end else if (take) begin
            spec_head_next  = ptr_add(spec_head, alloc_cnt);
            spec_count_next = spec_count - alloc_cnt + push_cnt;
        end else begin
            spec_head_next  = spec_head;
            spec_count_next = spec_count + push_cnt;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_head  <= '0;
            ret_head   <= '0;
            tail       <= '0;
            spec_count <= `FREE_CNT_W'(SIZE);
            for (int i = 0; i < SIZE; i++) begin
                ring[i] <= rename_pkg::prn_t'(`ARCH_REGS + i);  // PRNs above the arch file
            end
        end else begin
            spec_head  <= spec_head_next;
            ret_head   <= ret_head_next;
            tail       <= tail_next;
            spec_count <= spec_count_next;
            for (int i = 0; i < `N_WAYS; i++) begin
                if (retire_valid[i]) begin
                    ring[push_idx[i]] <= freed_prn[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/retire_map.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rename_settings.svh"

module retire_map (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                  [`N_WAYS-1:0]     retire_valid,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]     retire_arch,
    input  rename_pkg::prn_t      [`N_WAYS-1:0]     retire_prn,

    output rename_pkg::prn_t      [`N_WAYS-1:0]     freed_prn,
    output rename_pkg::prn_t      [`ARCH_REGS-1:0]  committed_map
);

    rename_pkg::prn_t [`ARCH_REGS-1:0] map_table;   // committed state

    always_comb begin
        committed_map = map_table;
        for (int i = 0; i < `N_WAYS; i++) begin
            freed_prn[i] = map_table[retire_arch[i]];

            // an older way in this group already displaced the mapping
            for (int j = 0; j < i; j++) begin
                if (retire_valid[j] && (retire_arch[j] == retire_arch[i])) begin
                    freed_prn[i] = retire_prn[j];
                end
            end

            if (retire_valid[i]) begin
                committed_map[retire_arch[i]] = retire_prn[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map_table[r] <= rename_pkg::prn_t'(r);
            end
        end else begin
            map_table <= committed_map;
        end
    end

endmodule

`default_nettype wire

/* design/rename_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rename_settings.svh"

module rename_top (
    input  logic                                    clock,
    input  logic                                    reset,

    input  logic                  [`N_WAYS-1:0]     dispatch_valid,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]     dispatch_dest,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]     dispatch_src1,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]     dispatch_src2,

    input  logic                  [`N_WAYS-1:0]     retire_valid,
    input  rename_pkg::arch_reg_t [`N_WAYS-1:0]     retire_arch,
    input  rename_pkg::prn_t      [`N_WAYS-1:0]     retire_prn,

    input  logic                                    squash,

    output logic                                    rename_stall,
    output rename_pkg::prn_t      [`N_WAYS-1:0]     dest_prn,
    output rename_pkg::prn_t      [`N_WAYS-1:0]     old_prn,
    output rename_pkg::prn_t      [`N_WAYS-1:0]     src1_prn,
    output rename_pkg::prn_t      [`N_WAYS-1:0]     src2_prn,
    output rename_pkg::prn_t      [`N_WAYS-1:0]     freed_prn
);

    rename_pkg::prn_t [`N_WAYS-1:0]   alloc_prn;      // next PRNs at the spec head
    rename_pkg::prn_t [`ARCH_REGS-1:0] committed_map;  // includes this cycle's retirements

    rename_map rename_map_inst (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .dispatch_src1  (dispatch_src1),
        .dispatch_src2  (dispatch_src2),
        .alloc_prn      (alloc_prn),
        .rename_stall   (rename_stall),
        .committed_map  (committed_map),
        .src1_prn       (src1_prn),
        .src2_prn       (src2_prn),
        .dest_prn       (dest_prn),
        .old_prn        (old_prn)
    );

    free_list #(
        .SIZE (`FREE_SIZE)
    ) free_list_inst (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .retire_valid   (retire_valid),
        .freed_prn      (freed_prn),
        .alloc_prn      (alloc_prn),
        .rename_stall   (rename_stall)
    );

    retire_map retire_map_inst (
        .clock          (clock),
        .reset          (reset),
        .retire_valid   (retire_valid),
        .retire_arch    (retire_arch),
        .retire_prn     (retire_prn),
        .freed_prn      (freed_prn),
        .committed_map  (committed_map)
    );

endmodule

`default_nettype wire

/* verif/rename_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rename_settings.svh"

module rename_assertions (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              squash,
    input  logic             [`N_WAYS-1:0]    dispatch_valid,
    input  logic                              rename_stall,
    input  rename_pkg::prn_t [`N_WAYS-1:0]    dest_prn,
    input  logic             [`N_WAYS-1:0]    retire_valid,
    input  rename_pkg::prn_t [`N_WAYS-1:0]    retire_prn,
    input  rename_pkg::prn_t [`N_WAYS-1:0]    freed_prn
);

    // a full group never gets the same PRN twice
    dest_unique: assert property (@(posedge clock) disable iff (reset)
        (&dispatch_valid && !rename_stall && !squash) |-> (dest_prn[0] != dest_prn[1]))
        else $error("both ways received dest_prn %0d", dest_prn[0]);

    stall_low_after_reset: assert property (@(posedge clock)
        reset |=> !rename_stall)
        else $error("rename_stall is high in the cycle after reset");

    for (genvar i = 0; i < `N_WAYS; i++) begin : g_freed
        // the displaced PRN is never the one being committed
        freed_not_new: assert property (@(posedge clock) disable iff (reset)
            retire_valid[i] |-> (freed_prn[i] != retire_prn[i]))
            else $error("way %0d freed its own retire_prn %0d", i, retire_prn[i]);
    end

endmodule

`default_nettype wire

/* verif/rename_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rename_settings.svh"

module rename_tb;

    localparam int WAIT_LIMIT    = 100;
    localparam int RANDOM_CYCLES = 2000;

    logic                                  clock;
    logic                                  reset;
    logic                                  squash;
    logic                  [`N_WAYS-1:0]   dispatch_valid;
    rename_pkg::arch_reg_t [`N_WAYS-1:0]   dispatch_dest;
    rename_pkg::arch_reg_t [`N_WAYS-1:0]   dispatch_src1;
    rename_pkg::arch_reg_t [`N_WAYS-1:0]   dispatch_src2;
    logic                  [`N_WAYS-1:0]   retire_valid;
    rename_pkg::arch_reg_t [`N_WAYS-1:0]   retire_arch;
    rename_pkg::prn_t      [`N_WAYS-1:0]   retire_prn;
    logic                                  rename_stall;
    rename_pkg::prn_t      [`N_WAYS-1:0]   dest_prn;
    rename_pkg::prn_t      [`N_WAYS-1:0]   old_prn;
    rename_pkg::prn_t      [`N_WAYS-1:0]   src1_prn;
    rename_pkg::prn_t      [`N_WAYS-1:0]   src2_prn;
    rename_pkg::prn_t      [`N_WAYS-1:0]   freed_prn;

    rename_pkg::prn_t      spec_map [`ARCH_REGS];  // model of the speculative map
    rename_pkg::prn_t      comm_map [`ARCH_REGS];
    rename_pkg::prn_t      spec_free [$];
    rename_pkg::prn_t      comm_free [$];          // stays full at FREE_SIZE entries
    rename_pkg::arch_reg_t fly_arch [$];           // renamed but not retired
    rename_pkg::prn_t      fly_new [$];
    rename_pkg::prn_t      fly_old [$];
    int                    seed;
    bit                    run_ok;
    bit                    fail_shown;

    rename_top rename_top_inst (.*);

    bind rename_top rename_assertions rename_assertions_inst (
        .clock(clock), .reset(reset), .squash(squash),
        .dispatch_valid(dispatch_valid), .rename_stall(rename_stall), .dest_prn(dest_prn),
        .retire_valid(retire_valid), .retire_prn(retire_prn), .freed_prn(freed_prn)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic stop_with_failure(input string why);
        fail_shown = 1'b1;
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic compare(input string name, input rename_pkg::prn_t got,
                           input rename_pkg::prn_t exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("error: %0.1f ns %s got %0d expected %0d",
                                        $realtime, name, got, exp));
        end
    endtask

    task automatic check_outputs();
        rename_pkg::prn_t new_prn [`N_WAYS];
        rename_pkg::prn_t exp_src1;
        rename_pkg::prn_t exp_src2;
        rename_pkg::prn_t exp_old;
        int               used;
        bit               stall_exp;

        stall_exp = (spec_free.size() < `N_WAYS);
        compare("rename_stall", rename_pkg::prn_t'(rename_stall), rename_pkg::prn_t'(stall_exp));
        used = 0;
        for (int i = 0; i < `N_WAYS; i++) begin
            new_prn[i] = (used < spec_free.size()) ? spec_free[used] : '0;
            exp_src1   = spec_map[dispatch_src1[i]];
            exp_src2   = spec_map[dispatch_src2[i]];
            exp_old    = spec_map[dispatch_dest[i]];
            for (int j = 0; j < i; j++) begin
                if (dispatch_valid[j] && dispatch_dest[j] == dispatch_src1[i]) begin
                    exp_src1 = new_prn[j];
                end
                if (dispatch_valid[j] && dispatch_dest[j] == dispatch_src2[i]) begin
                    exp_src2 = new_prn[j];
                end
                if (dispatch_valid[j] && dispatch_dest[j] == dispatch_dest[i]) begin
                    exp_old = new_prn[j];
                end
            end
            compare($sformatf("src1_prn[%0d]", i), src1_prn[i], exp_src1);
            compare($sformatf("src2_prn[%0d]", i), src2_prn[i], exp_src2);
            compare($sformatf("old_prn[%0d]", i), old_prn[i], exp_old);
            if (!stall_exp) begin
                compare($sformatf("dest_prn[%0d]", i), dest_prn[i], new_prn[i]);
            end
            if (dispatch_valid[i]) begin
                used++;
            end
            if (retire_valid[i]) begin
                compare($sformatf("freed_prn[%0d]", i), freed_prn[i], fly_old[i]);
            end
        end
    endtask

    task automatic update_model();
        rename_pkg::prn_t      freed [$];
        rename_pkg::arch_reg_t arch;
        bit                    stalled;

        stalled = (spec_free.size() < `N_WAYS);
        for (int i = 0; i < `N_WAYS; i++) begin
            if (retire_valid[i]) begin
                arch = fly_arch.pop_front();
                comm_map[arch] = fly_new.pop_front();
                freed.push_back(fly_old.pop_front());
                void'(comm_free.pop_front());  // that entry went to the retiring op
                comm_free.push_back(freed[$]);
            end
        end
        if (squash) begin
            spec_map  = comm_map;
            spec_free = comm_free;
            fly_arch.delete();
            fly_new.delete();
            fly_old.delete();
        end else begin
            for (int i = 0; i < `N_WAYS; i++) begin
                if (dispatch_valid[i] && !stalled) begin
                    fly_arch.push_back(dispatch_dest[i]);
                    fly_old.push_back(spec_map[dispatch_dest[i]]);
                    fly_new.push_back(spec_free.pop_front());
                    spec_map[dispatch_dest[i]] = fly_new[$];
                end
            end
            foreach (freed[k]) begin
                spec_free.push_back(freed[k]);
            end
        end
    endtask

    // check before the edge, update the model on it, drive again 1 ns later
    task automatic run_cycle();
        @(negedge clock);
        check_outputs();
        @(posedge clock);
        update_model();
        #1;
    endtask

    task automatic clear_inputs();
        squash         = 1'b0;
        dispatch_valid = '0;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        retire_valid   = '0;
        retire_arch    = '0;
        retire_prn     = '0;
    endtask

    task automatic drive_group(input logic [`N_WAYS-1:0] valid);
        logic [31:0] r;

        for (int i = 0; i < `N_WAYS; i++) begin
            r = rand_word();
            dispatch_dest[i] = r[`ARCH_W-1:0];
            dispatch_src1[i] = r[2*`ARCH_W-1:`ARCH_W];
            dispatch_src2[i] = r[3*`ARCH_W-1:2*`ARCH_W];
        end
        dispatch_valid = valid;
    endtask

    // oldest in-flight records retire first, from way 0 up
    task automatic drive_retire(input int n);
        retire_valid = '0;
        for (int i = 0; i < `N_WAYS; i++) begin
            if (i < n && i < fly_arch.size()) begin
                retire_valid[i] = 1'b1;
                retire_arch[i]  = fly_arch[i];
                retire_prn[i]   = fly_new[i];
            end
        end
    endtask

    task automatic retire_until(input bit until_empty);
        int waited;

        waited = 0;
        while (until_empty ? (fly_arch.size() > 0) : rename_stall) begin
            if (waited == WAIT_LIMIT) begin
                stop_with_failure("retirement did not drain the pipe or clear the stall in time");
            end else begin
                drive_retire(`N_WAYS);
                run_cycle();
                waited++;
            end
        end
        retire_valid = '0;
    endtask

    task automatic sweep_sources();
        for (int r = 0; r < `ARCH_REGS; r += 4) begin
            dispatch_src1[0] = rename_pkg::arch_reg_t'(r);
            dispatch_src2[0] = rename_pkg::arch_reg_t'(r + 1);
            dispatch_src1[1] = rename_pkg::arch_reg_t'(r + 2);
            dispatch_src2[1] = rename_pkg::arch_reg_t'(r + 3);
            run_cycle();
        end
    endtask

    initial begin
        logic [31:0] r;

        seed       = 32'hbc31;
        run_ok     = 1'b0;
        fail_shown = 1'b0;
        reset      = 1'b1;
        clear_inputs();
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int a = 0; a < `ARCH_REGS; a++) begin
            spec_map[a] = rename_pkg::prn_t'(a);
            comm_map[a] = rename_pkg::prn_t'(a);
        end
        for (int k = 0; k < `FREE_SIZE; k++) begin
            spec_free.push_back(rename_pkg::prn_t'(`ARCH_REGS + k));
            comm_free.push_back(rename_pkg::prn_t'(`ARCH_REGS + k));
        end

        sweep_sources();            // identity map out of reset
        drive_group(2'b11);         // first allocations are 32 and 33
        run_cycle();

        dispatch_dest  = {rename_pkg::arch_reg_t'(7), rename_pkg::arch_reg_t'(7)};
        dispatch_src1  = {rename_pkg::arch_reg_t'(7), rename_pkg::arch_reg_t'(3)};
        dispatch_src2  = {rename_pkg::arch_reg_t'(7), rename_pkg::arch_reg_t'(9)};
        run_cycle();

        repeat (14) begin
            drive_group(2'b11);
            run_cycle();
        end
        compare("rename_stall", rename_pkg::prn_t'(rename_stall), rename_pkg::prn_t'(1));
        drive_group(2'b11);         // held while stalled
        repeat (3) run_cycle();

        dispatch_valid = '0;
        retire_until(1'b0);
        retire_until(1'b1);
        repeat (8) begin            // reuses freed PRNs past the wrap
            drive_group(2'b11);
            run_cycle();
        end

        drive_group(2'b11);
        drive_retire(2);
        squash = 1'b1;
        run_cycle();
        clear_inputs();
        sweep_sources();
        drive_group(2'b11);
        run_cycle();

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            r = rand_word();
            drive_group(r[1:0]);
            drive_retire(int'(r[3:2]));
            squash = (r[8:4] == 5'd0);
            run_cycle();
        end

        clear_inputs();
        run_cycle();
        run_ok = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

    final begin
        if (!run_ok && !fail_shown) begin
            $display("*** TEST FAILED ***");
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/rename_pkg.sv
design/rename_map.sv
design/free_list.sv
design/retire_map.sv
design/rename_top.sv
verif/rename_assertions.sv
verif/rename_tb.sv

/* run.sh */
#!/bin/sh
# build the rename testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module rename_tb -f filelist.f -o rename_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
exit 0
